// ==== verilog/vic_mem_pkg.sv ====
package vic_mem_pkg;

	//////////////////////////////////////////////////////////////////////
	// Memory map

	localparam int NUM_BANKS = 8;

	typedef logic [15:0]                  addr_t;
	typedef logic [7:0]                   byte_t;
	typedef logic [24:0]                  dl_addr_t;
	typedef logic [7:0]                   dl_index_t;
	typedef logic [$clog2(NUM_BANKS)-1:0] bank_idx_t;
	typedef logic [12:0]                  bank_offset_t;
	typedef logic [NUM_BANKS-1:0]         bank_mask_t;

	// Loader phases
	typedef enum logic [2:0] {
		IDLE,
		PRG_DATA,
		CART_DATA,
		FIXUP_WRITE,
		FIXUP_GAP
	} loader_state_e;

	localparam addr_t PRG_LIMIT  = 16'hA000;
	localparam addr_t CART_LIMIT = 16'hC000;

	// Download file index, as set by the file selector
	localparam dl_index_t DL_INDEX_PRG      = 8'd1;
	localparam dl_index_t DL_INDEX_CART_HDR = 8'd2;
	localparam dl_index_t DL_INDEX_CART_RAW = 8'd3;

	localparam bank_mask_t BASE_BANK_MASK = 8'b0000_0001;
	localparam bank_idx_t  EXTRAM3_BANK   = 3'd5;
	// Character ROM area, never taken by a cartridge
	localparam bank_idx_t  NO_CART_BANK   = 3'd4;
	localparam byte_t      OPEN_BUS       = 8'hFF;

	//////////////////////////////////////////////////////////////////////
	// BASIC pointers patched after a program load
	// Even entries take the low byte of the end address, odd the high byte

	localparam int FIXUP_COUNT = 8;

	localparam addr_t FIXUP_ADDR [FIXUP_COUNT] = '{
		16'h002D, 16'h002E,
		16'h002F, 16'h0030,
		16'h0031, 16'h0032,
		16'h00AE, 16'h00AF
	};

endpackage

// ==== verilog/prg_loader.sv ====
`timescale 1ns/10ps

module prg_loader import vic_mem_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       dl_active_i,
	input  dl_index_t  dl_index_i,
	input  logic       dl_wr_i,
	input  dl_addr_t   dl_addr_i,
	input  byte_t      dl_data_i,
	input  byte_t      dl_ext_i,
	output logic       ld_wr_o,
	output addr_t      ld_addr_o,
	output byte_t      ld_data_o,
	output bank_mask_t cart_mask_o
);

	loader_state_e state;
	logic          active_q;
	logic [$clog2(FIXUP_COUNT)-1:0] fix_idx;

	// Running load address, also the end address for the fixup
	addr_t     run_addr;
	bank_idx_t run_bank;
	addr_t     raw_base;

	logic dl_start;
	logic in_prg;
	logic in_cart;
	logic has_header;
	logic byte_strobe;
	logic hdr_lo;
	logic hdr_hi;
	logic prg_byte;
	logic cart_byte;
	logic fix_write;
	logic raw_start;

	//////////////////////////////////////////////////////////////////////
	// Stream decode

	assign dl_start = dl_active_i & ~active_q;
	assign in_prg   = (state == PRG_DATA);
	assign in_cart  = (state == CART_DATA);
	assign run_bank = run_addr[15:13];

	// Raw cartridges carry no header
	assign has_header = in_prg | (in_cart & (dl_index_i == DL_INDEX_CART_HDR));

	assign byte_strobe = (in_prg | in_cart) & dl_active_i & dl_wr_i;
	assign hdr_lo      = byte_strobe & has_header & (dl_addr_i == '0);
	assign hdr_hi      = byte_strobe & has_header & (dl_addr_i == dl_addr_t'(1));

	assign prg_byte  = byte_strobe & in_prg & ~hdr_lo & ~hdr_hi & (run_addr < PRG_LIMIT);
	assign cart_byte = byte_strobe & in_cart & ~hdr_lo & ~hdr_hi & (run_addr < CART_LIMIT);
	assign fix_write = (state == FIXUP_WRITE);
	assign raw_start = dl_start & (state == IDLE) & (dl_index_i == DL_INDEX_CART_RAW);

	// Start address from the last extension character, 4 KB steps
	always_comb begin
		raw_base = CART_LIMIT;
		if (dl_ext_i >= "2" && dl_ext_i <= "9") begin
			raw_base = {dl_ext_i[3:0], 12'h000};
		end else if (dl_ext_i >= "A" && dl_ext_i <= "B") begin
			raw_base = {dl_ext_i[3:0] + 4'd9, 12'h000};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= IDLE;
			active_q    <= 1'b0;
			fix_idx     <= '0;
			ld_wr_o     <= 1'b0;
			cart_mask_o <= '0;
		end else begin
			active_q <= dl_active_i;
			ld_wr_o  <= prg_byte | cart_byte | fix_write;

			if (cart_byte && run_bank != NO_CART_BANK) begin
				cart_mask_o[run_bank] <= 1'b1;
			end

			case (state)
				IDLE: begin
					if (dl_start) begin
						if (dl_index_i == DL_INDEX_PRG) begin
							state <= PRG_DATA;
						end else if (dl_index_i == DL_INDEX_CART_HDR ||
								dl_index_i == DL_INDEX_CART_RAW) begin
							state <= CART_DATA;
						end
					end
				end
				PRG_DATA: begin
					// End of file starts the pointer patch
					if (!dl_active_i) begin
						state   <= FIXUP_WRITE;
						fix_idx <= '0;
					end
				end
				CART_DATA: begin
					if (!dl_active_i) begin
						state <= IDLE;
					end
				end
				FIXUP_WRITE: begin
					state <= FIXUP_GAP;
				end
				FIXUP_GAP: begin
					if (fix_idx == ($clog2(FIXUP_COUNT))'(FIXUP_COUNT - 1)) begin
						state <= IDLE;
					end else begin
						fix_idx <= fix_idx + 1'b1;
						state   <= FIXUP_WRITE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Address and write data

	always_ff @(posedge clk_sys) begin
		if (raw_start) begin
			run_addr <= raw_base;
		end else if (hdr_lo) begin
			run_addr[7:0] <= dl_data_i;
		end else if (hdr_hi) begin
			run_addr[15:8] <= dl_data_i;
		end else if (prg_byte || cart_byte) begin
			run_addr <= run_addr + 1'b1;
		end

		if (prg_byte || cart_byte) begin
			ld_addr_o <= run_addr;
			ld_data_o <= dl_data_i;
		end else if (fix_write) begin
			ld_addr_o <= FIXUP_ADDR[fix_idx];
			ld_data_o <= fix_idx[0] ? run_addr[15:8] : run_addr[7:0];
		end
	end

	// Fixup writes are single pulses separated by a gap
	a_fixup_spacing: assert property (@(posedge clk_sys) disable iff (reset)
		(ld_wr_o && (state == FIXUP_WRITE || state == FIXUP_GAP)) |=> !ld_wr_o);

endmodule

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/10ps

module mem_arbiter import vic_mem_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         wb_cyc_i,
	input  logic         wb_stb_i,
	input  logic         wb_we_i,
	input  addr_t        wb_adr_i,
	input  byte_t        wb_dat_i,
	input  logic         wb_ack_i,
	input  logic         ld_wr_i,
	input  addr_t        ld_addr_i,
	input  byte_t        ld_data_i,
	input  bank_mask_t   cart_mask_i,
	input  logic [1:0]   extram2_sel_i,
	input  logic         extram3_i,
	input  logic         cart_writable_i,
	output bank_mask_t   bank_ld_wr_o,
	output bank_mask_t   bank_bus_en_o,
	output logic         bus_we_o,
	output bank_offset_t offset_o,
	output byte_t        wdata_o,
	output bank_mask_t   present_o,
	output bank_mask_t   read_only_o,
	output bank_idx_t    accept_idx_o,
	output logic         accept_o
);

	bank_mask_t exp_mask;
	bank_mask_t exp_mask_q;
	logic       writable_q;
	logic       ack_q;
	bank_idx_t  ld_bank;

	//////////////////////////////////////////////////////////////////////
	// Expansion map

	always_comb begin
		exp_mask = BASE_BANK_MASK;
		case (extram2_sel_i)
			2'd1: exp_mask[1]   = 1'b1;
			2'd2: exp_mask[2:1] = 2'b11;
			2'd3: exp_mask[3:1] = 3'b111;
			default: ;
		endcase
		if (extram3_i) begin
			exp_mask[EXTRAM3_BANK] = 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			exp_mask_q <= BASE_BANK_MASK;
			writable_q <= 1'b0;
			ack_q      <= 1'b0;
		end else begin
			exp_mask_q <= exp_mask;
			writable_q <= cart_writable_i;
			ack_q      <= wb_ack_i;
		end
	end

	// Cartridge banks follow the loader mask without delay
	assign present_o   = exp_mask_q | cart_mask_i;
	assign read_only_o = writable_q ? '0 : cart_mask_i;

	//////////////////////////////////////////////////////////////////////
	// Request selection with the loader first

	// Hold off one extra edge after ack so a late stb release is not served twice
	assign accept_o     = wb_cyc_i & wb_stb_i & ~ld_wr_i & ~wb_ack_i & ~ack_q;
	assign accept_idx_o = wb_adr_i[15:13];
	assign ld_bank      = ld_addr_i[15:13];

	assign bank_ld_wr_o  = ld_wr_i ? (bank_mask_t'(1) << ld_bank) : '0;
	assign bank_bus_en_o = accept_o ? (bank_mask_t'(1) << accept_idx_o) : '0;
	assign bus_we_o      = accept_o & wb_we_i;
	assign offset_o      = ld_wr_i ? ld_addr_i[12:0] : wb_adr_i[12:0];
	assign wdata_o       = ld_wr_i ? ld_data_i : wb_dat_i;

	// Every bank enable is answered by the ack in the next cycle
	a_bus_en_acked: assert property (@(posedge clk_sys) disable iff (reset)
		(bank_bus_en_o != '0) |=> wb_ack_i);

endmodule

// ==== verilog/mem_bank.sv ====
`timescale 1ns/10ps

module mem_bank import vic_mem_pkg::*; (
	input  logic         clk_sys,
	input  logic         ld_wr_i,
	input  logic         bus_en_i,
	input  logic         bus_we_i,
	input  bank_offset_t offset_i,
	input  byte_t        wdata_i,
	input  logic         present_i,
	input  logic         read_only_i,
	output byte_t        rdata_o
);

	// 8 KB of storage
	byte_t mem [2 ** $bits(bank_offset_t)];

	logic ld_write;
	logic bus_write;
	logic wr_en;

	//////////////////////////////////////////////////////////////////////
	// Write gating

	// Loader bypasses write protection
	assign ld_write = ld_wr_i & present_i;

	assign bus_write = bus_en_i & bus_we_i & present_i & ~read_only_i;
	assign wr_en     = ld_write | bus_write;

	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[offset_i] <= wdata_i;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Registered read

	always_ff @(posedge clk_sys) begin
		if (bus_en_i) begin
			// Absent bank floats high
			rdata_o <= present_i ? mem[offset_i] : OPEN_BUS;
		end
	end

	// Loader and bus never share the port in one cycle
	a_port_exclusive: assert property (@(posedge clk_sys)
		ld_wr_i |-> !bus_en_i);

endmodule

// ==== verilog/bus_return.sv ====
`timescale 1ns/10ps

module bus_return import vic_mem_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  accept_i,
	input  bank_idx_t             accept_idx_i,
	input  byte_t [NUM_BANKS-1:0] bank_rdata_i,
	output byte_t                 wb_dat_o,
	output logic                  wb_ack_o
);

	// Bank that owns the access in flight
	bank_idx_t ack_idx;

	//////////////////////////////////////////////////////////////////////
	// Acknowledge

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= accept_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept_i) begin
			ack_idx <= accept_idx_i;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read data

	// Bank read register is loaded on the accepting edge
	assign wb_dat_o = wb_ack_o ? bank_rdata_i[ack_idx] : '0;

	a_ack_single: assert property (@(posedge clk_sys) disable iff (reset)
		wb_ack_o |=> !wb_ack_o);

endmodule

// ==== verilog/vic_expansion_top.sv ====
`timescale 1ns/10ps

module vic_expansion_top import vic_mem_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       dl_active_i,
	input  dl_index_t  dl_index_i,
	input  logic       dl_wr_i,
	input  dl_addr_t   dl_addr_i,
	input  byte_t      dl_data_i,
	input  byte_t      dl_ext_i,
	input  logic       wb_cyc_i,
	input  logic       wb_stb_i,
	input  logic       wb_we_i,
	input  addr_t      wb_adr_i,
	input  byte_t      wb_dat_i,
	output byte_t      wb_dat_o,
	output logic       wb_ack_o,
	input  logic [1:0] extram2_sel_i,
	input  logic       extram3_i,
	input  logic       cart_writable_i
);

	// Loader write path
	logic       ld_wr;
	addr_t      ld_addr;
	byte_t      ld_data;
	bank_mask_t cart_mask;

	// Bank side
	bank_mask_t            bank_ld_wr;
	bank_mask_t            bank_bus_en;
	logic                  bus_we;
	bank_offset_t          bank_offset;
	byte_t                 bank_wdata;
	bank_mask_t            bank_present;
	bank_mask_t            bank_read_only;
	byte_t [NUM_BANKS-1:0] bank_rdata;

	bank_idx_t accept_idx;
	logic      accept;

	prg_loader prg_loader_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.dl_ext_i    (dl_ext_i),
		.ld_wr_o     (ld_wr),
		.ld_addr_o   (ld_addr),
		.ld_data_o   (ld_data),
		.cart_mask_o (cart_mask)
	);

	mem_arbiter mem_arbiter_i (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.wb_cyc_i        (wb_cyc_i),
		.wb_stb_i        (wb_stb_i),
		.wb_we_i         (wb_we_i),
		.wb_adr_i        (wb_adr_i),
		.wb_dat_i        (wb_dat_i),
		.wb_ack_i        (wb_ack_o),
		.ld_wr_i         (ld_wr),
		.ld_addr_i       (ld_addr),
		.ld_data_i       (ld_data),
		.cart_mask_i     (cart_mask),
		.extram2_sel_i   (extram2_sel_i),
		.extram3_i       (extram3_i),
		.cart_writable_i (cart_writable_i),
		.bank_ld_wr_o    (bank_ld_wr),
		.bank_bus_en_o   (bank_bus_en),
		.bus_we_o        (bus_we),
		.offset_o        (bank_offset),
		.wdata_o         (bank_wdata),
		.present_o       (bank_present),
		.read_only_o     (bank_read_only),
		.accept_idx_o    (accept_idx),
		.accept_o        (accept)
	);

	//////////////////////////////////////////////////////////////////////
	// Eight 8 KB banks covering $0000-$FFFF

	for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
		mem_bank mem_bank_i (
			.clk_sys     (clk_sys),
			.ld_wr_i     (bank_ld_wr[g]),
			.bus_en_i    (bank_bus_en[g]),
			.bus_we_i    (bus_we),
			.offset_i    (bank_offset),
			.wdata_i     (bank_wdata),
			.present_i   (bank_present[g]),
			.read_only_i (bank_read_only[g]),
			.rdata_o     (bank_rdata[g])
		);
	end

	bus_return bus_return_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.accept_i     (accept),
		.accept_idx_i (accept_idx),
		.bank_rdata_i (bank_rdata),
		.wb_dat_o     (wb_dat_o),
		.wb_ack_o     (wb_ack_o)
	);

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk_sys_o,
	output logic reset_o
);

	// 40 ns period
	initial begin
		clk_sys_o = 1'b0;
		forever #20 clk_sys_o = ~clk_sys_o;
	end

	// Held over two rising edges, released on a falling edge
	initial begin
		reset_o = 1'b1;
		repeat (2) @(posedge clk_sys_o);
		@(negedge clk_sys_o);
		reset_o = 1'b0;
	end

endmodule

// ==== dv/tb_vic_expansion.sv ====
`timescale 1ns/10ps

module tb_vic_expansion import vic_mem_pkg::*; ();

	typedef enum logic [2:0] {OP_CFG, OP_PRG, OP_CRT, OP_RAW, OP_WR, OP_RD, OP_RST, OP_MIX} op_e;

	// CFG arg: [1:0] extram2 select, [2] extram3, [3] cart writable
	typedef struct packed {
		logic [2:0]  test;
		op_e         op;
		addr_t       addr;
		byte_t       arg;
		logic [7:0]  count;
	} step_t;

	logic       clk_sys, por_reset, sw_reset;
	logic       dl_active, dl_wr;
	dl_index_t  dl_index;
	dl_addr_t   dl_addr;
	byte_t      dl_data, dl_ext;
	logic       wb_cyc, wb_stb, wb_we, wb_ack;
	addr_t      wb_adr;
	byte_t      wb_wdata, wb_rdata;
	logic [1:0] extram2_sel;
	logic       extram3, cart_writable;

	step_t  steps [$];
	string  names [7];
	string  cur_name;
	int     checks, errors, test_errs, tests_run;
	int     budget_cycles = 0;
	byte_t  exp_bank1 [8192];
	logic [31:0] lcg_state = 32'h471f;

	tb_clock_gen tb_clock_gen_i (.clk_sys_o(clk_sys), .reset_o(por_reset));

	vic_expansion_top vic_expansion_top_i (
		.clk_sys(clk_sys), .reset(por_reset | sw_reset),
		.dl_active_i(dl_active), .dl_index_i(dl_index), .dl_wr_i(dl_wr),
		.dl_addr_i(dl_addr), .dl_data_i(dl_data), .dl_ext_i(dl_ext),
		.wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
		.wb_dat_i(wb_wdata), .wb_dat_o(wb_rdata), .wb_ack_o(wb_ack),
		.extram2_sel_i(extram2_sel), .extram3_i(extram3), .cart_writable_i(cart_writable)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic add_step(input int test, input op_e op, input addr_t addr,
			input byte_t arg, input int count);
		steps.push_back({test[2:0], op, addr, arg, count[7:0]});
	endtask

	task automatic check_byte(input addr_t a, input byte_t exp, input byte_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			test_errs++;
			$display("** Error: %s: $%h expected %h, actual %h", cur_name, a, exp, act);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Wishbone master, one access at a time

	task automatic bus_access(input logic we, input addr_t a, input byte_t d,
			output byte_t rd, output logic ok);
		int waited;
		waited = 0;
		@(negedge clk_sys);
		{wb_cyc, wb_stb, wb_we, wb_adr, wb_wdata} = {1'b1, 1'b1, we, a, d};
		do begin
			@(negedge clk_sys);
			waited++;
		end while (!wb_ack && waited < 16);
		ok = wb_ack;
		rd = wb_rdata;
		{wb_cyc, wb_stb, wb_we} = 3'b000;
		if (!ok) begin
			errors++;
			test_errs++;
			$display("%s: no acknowledge for the access to $%h", cur_name, a);
		end else begin
			@(negedge clk_sys);
			if (wb_ack) begin
				errors++;
				test_errs++;
				ok = 1'b0;
				$display("%s: a second acknowledge followed the access to $%h", cur_name, a);
			end
		end
	endtask

	// Strobe every second cycle, then leave time for the pointer patch
	task automatic stream_file(input dl_index_t idx, input byte_t ext, input logic hdr,
			input addr_t start, input byte_t seed, input int count);
		byte_t bytes [$];
		if (hdr) begin
			bytes.push_back(start[7:0]);
			bytes.push_back(start[15:8]);
		end
		for (int k = 0; k < count; k++) bytes.push_back(seed + k[7:0]);
		@(negedge clk_sys);
		{dl_active, dl_index, dl_ext} = {1'b1, idx, ext};
		foreach (bytes[i]) begin
			@(negedge clk_sys);
			{dl_wr, dl_addr, dl_data} = {1'b1, dl_addr_t'(i), bytes[i]};
			@(negedge clk_sys);
			dl_wr = 1'b0;
		end
		@(negedge clk_sys);
		dl_active = 1'b0;
		repeat (20) @(negedge clk_sys);
	endtask

	// Bus writes into bank 1 while a program file streams in
	task automatic mix_traffic(input step_t st);
		addr_t  a;
		byte_t  rd;
		logic   ok;
		addr_t  written [$];
		fork
			stream_file(8'd1, 8'h00, 1'b1, st.addr, st.arg, st.count);
			repeat (16) begin
				lcg_state = lcg_next(lcg_state);
				a = {3'b001, lcg_state[28:16]};
				exp_bank1[a[12:0]] = lcg_state[15:8];
				written.push_back(a);
				bus_access(1'b1, a, lcg_state[15:8], rd, ok);
			end
		join
		foreach (written[i]) begin
			bus_access(1'b0, written[i], 8'h00, rd, ok);
			if (ok) check_byte(written[i], exp_bank1[written[i][12:0]], rd);
		end
	endtask

	task automatic run_step(input step_t st);
		byte_t rd;
		logic  ok;
		case (st.op)
			OP_CFG: begin
				@(negedge clk_sys);
				{cart_writable, extram3, extram2_sel} = st.arg[3:0];
			end
			OP_PRG: stream_file(8'd1, 8'h00, 1'b1, st.addr, st.arg, st.count);
			OP_CRT: stream_file(8'd2, 8'h00, 1'b1, st.addr, st.arg, st.count);
			OP_RAW: stream_file(8'd3, st.addr[7:0], 1'b0, 16'h0000, st.arg, st.count);
			OP_WR:  bus_access(1'b1, st.addr, st.arg, rd, ok);
			OP_RD: begin
				for (int k = 0; k < st.count; k++) begin
					bus_access(1'b0, st.addr + k[15:0], 8'h00, rd, ok);
					if (ok) check_byte(st.addr + k[15:0], st.arg + k[7:0], rd);
				end
			end
			OP_RST: begin
				@(negedge clk_sys);
				sw_reset = 1'b1;
				repeat (2) @(negedge clk_sys);
				sw_reset = 1'b0;
			end
			default: mix_traffic(st);
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test table

	task automatic build_table();
		names = '{"prg_load", "ptr_fixup", "prg_limit", "cart_header", "cart_raw",
			"expansion_map", "contention"};
		add_step(0, OP_CFG, 16'h0000, 8'h00, 1);
		add_step(0, OP_PRG, 16'h1001, 8'h10, 16);
		add_step(0, OP_RD,  16'h1001, 8'h10, 16);
		// End address $1011
		add_step(1, OP_RD,  16'h002D, 8'h11, 1);
		add_step(1, OP_RD,  16'h002E, 8'h10, 1);
		add_step(1, OP_RD,  16'h002F, 8'h11, 1);
		add_step(1, OP_RD,  16'h0030, 8'h10, 1);
		add_step(1, OP_RD,  16'h0031, 8'h11, 1);
		add_step(1, OP_RD,  16'h0032, 8'h10, 1);
		add_step(1, OP_RD,  16'h00AE, 8'h11, 1);
		add_step(1, OP_RD,  16'h00AF, 8'h10, 1);
		// Bank 5 switched in so a spill past $A000 would show
		add_step(2, OP_CFG, 16'h0000, 8'h04, 1);
		add_step(2, OP_WR,  16'hA000, 8'h5A, 1);
		add_step(2, OP_PRG, 16'h9FF8, 8'h80, 12);
		add_step(2, OP_RD,  16'h9FF8, 8'hFF, 1);
		add_step(2, OP_RD,  16'hA000, 8'h5A, 1);
		add_step(2, OP_RD,  16'h002D, 8'h00, 1);
		add_step(2, OP_RD,  16'h002E, 8'hA0, 1);
		add_step(2, OP_CFG, 16'h0000, 8'h00, 1);
		add_step(2, OP_RD,  16'hA000, 8'hFF, 1);
		add_step(3, OP_CRT, 16'hA000, 8'h40, 8);
		add_step(3, OP_RD,  16'hA000, 8'h40, 8);
		add_step(3, OP_WR,  16'hA003, 8'hEE, 1);
		add_step(3, OP_RD,  16'hA003, 8'h43, 1);
		add_step(3, OP_CFG, 16'h0000, 8'h08, 1);
		add_step(3, OP_WR,  16'hA003, 8'hEE, 1);
		add_step(3, OP_RD,  16'hA003, 8'hEE, 1);
		add_step(4, OP_CFG, 16'h0000, 8'h00, 1);
		add_step(4, OP_RAW, 16'h0036, 8'h60, 8);
		add_step(4, OP_RD,  16'h6000, 8'h60, 8);
		add_step(4, OP_RST, 16'h0000, 8'h00, 1);
		add_step(4, OP_RD,  16'h6000, 8'hFF, 1);
		add_step(4, OP_RD,  16'hA000, 8'hFF, 1);
		add_step(5, OP_CFG, 16'h0000, 8'h02, 1);
		add_step(5, OP_WR,  16'h2000, 8'hA5, 1);
		add_step(5, OP_WR,  16'h5FFF, 8'h5A, 1);
		add_step(5, OP_RD,  16'h2000, 8'hA5, 1);
		add_step(5, OP_RD,  16'h5FFF, 8'h5A, 1);
		add_step(5, OP_WR,  16'h6000, 8'h33, 1);
		add_step(5, OP_RD,  16'h6000, 8'hFF, 1);
		add_step(5, OP_RD,  16'h8000, 8'hFF, 1);
		add_step(5, OP_CFG, 16'h0000, 8'h07, 1);
		add_step(5, OP_RD,  16'h8000, 8'hFF, 1);
		add_step(6, OP_CFG, 16'h0000, 8'h03, 1);
		add_step(6, OP_MIX, 16'h1100, 8'hC0, 24);
		add_step(6, OP_RD,  16'h1100, 8'hC0, 24);
	endtask

	initial begin
		{dl_active, dl_wr, dl_index, dl_addr, dl_data, dl_ext} = '0;
		{wb_cyc, wb_stb, wb_we, wb_adr, wb_wdata} = '0;
		{extram2_sel, extram3, cart_writable, sw_reset} = '0;
		{checks, errors, test_errs, tests_run} = '0;
		build_table();
		foreach (steps[i]) begin
			budget_cycles += (steps[i].op == OP_MIX) ? 400 : 48 + 8 * steps[i].count;
		end
		wait (!por_reset);
		foreach (steps[i]) begin
			cur_name = names[steps[i].test];
			run_step(steps[i]);
			if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test) begin
				$display("test %s done, %0d errors", cur_name, test_errs);
				tests_run++;
				test_errs = 0;
			end
		end
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// Limit from the summed step lengths plus margin
	initial begin
		wait (budget_cycles > 0);
		#(budget_cycles * 40 + 4000);
		$display("Watchdog expired before the test table finished");
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
verilog/vic_mem_pkg.sv
verilog/prg_loader.sv
verilog/mem_arbiter.sv
verilog/mem_bank.sv
verilog/bus_return.sv
verilog/vic_expansion_top.sv
dv/tb_clock_gen.sv
dv/tb_vic_expansion.sv

// ==== Bender.yml ====
package:
  name: vic_expansion

sources:
  - verilog/vic_mem_pkg.sv
  - verilog/prg_loader.sv
  - verilog/mem_arbiter.sv
  - verilog/mem_bank.sv
  - verilog/bus_return.sv
  - verilog/vic_expansion_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/tb_vic_expansion.sv
